/* design/cpu_pkg.sv */
package cpu_pkg;

    // first fetch address after reset
    localparam logic [31:0] RESET_PC = 32'h1c000000;

    // fetch address error
    localparam logic [5:0] ECODE_ADEF = 6'h08;

    // on-chip RAM depth in 32-bit words
    localparam int MEM_WORDS = 256;

    // one master's request on the SRAM-like bus
    typedef struct packed {
        logic        req;
        logic        wr;
        logic [1:0]  size;
        logic [31:0] addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } mem_req_t;

    // slave reply seen by one master
    typedef struct packed {
        logic        addr_ok;
        logic        data_ok;
        logic [31:0] rdata;
    } mem_resp_t;

    // item handed to decode
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        has_exception;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
    } fetch_out_t;

    typedef enum logic [1:0] {
        RD_NONE,
        RD_BRANCH,
        RD_EXCEPTION,
        RD_ERTN
    } redirect_e;

    typedef enum logic {
        LSU_LOAD,
        LSU_STORE
    } lsu_op_e;

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_DATA,
        OWN_FETCH
    } arb_owner_e;

endpackage

/* design/fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage (
    input  logic                clk,
    input  logic                rst,
    input  cpu_pkg::redirect_e  redirect_kind,
    input  logic [31:0]         redirect_target,
    output cpu_pkg::mem_req_t   bus_req,
    input  cpu_pkg::mem_resp_t  bus_resp,
    output logic                out_valid,
    input  logic                out_ready,
    output cpu_pkg::fetch_out_t fetch_out
);
    import cpu_pkg::*;

    // exception ranks above ertn, ertn above branch
    function automatic logic [1:0] rd_prio(redirect_e kind);
        case (kind)
            RD_EXCEPTION: rd_prio = 2'd3;
            RD_ERTN:      rd_prio = 2'd2;
            RD_BRANCH:    rd_prio = 2'd1;
            default:      rd_prio = 2'd0;
        endcase
    endfunction

    logic        fetch_en_q;
    logic [31:0] pc_q;
    redirect_e   held_kind_q;
    logic [31:0] held_target_q;
    logic        pend_q;
    logic        pend_cancel_q;
    logic        buf_valid_q;
    fetch_out_t  buf_q;
    logic        out_valid_q;
    fetch_out_t  out_q;

    logic        redirect_now;
    redirect_e   eff_kind;
    logic [31:0] eff_target;
    logic [31:0] next_pc;
    logic        issue_ok;
    logic        accept;
    logic        adef;
    logic        ret_ok;
    fetch_out_t  ret_item;
    logic        out_fire;
    logic        out_free;

    assign redirect_now = redirect_kind != RD_NONE;

    // new pulse replaces the held one unless the held one ranks higher
    always_comb begin
        if (redirect_now && rd_prio(redirect_kind) >= rd_prio(held_kind_q)) begin
            eff_kind   = redirect_kind;
            eff_target = redirect_target;
        end else begin
            eff_kind   = held_kind_q;
            eff_target = held_target_q;
        end
    end

    assign next_pc = (eff_kind != RD_NONE) ? eff_target : pc_q + 32'd4;

    // one fetch in flight, and only while the buffer is empty
    assign issue_ok = fetch_en_q && !pend_q && !buf_valid_q;
    assign accept   = bus_req.req && bus_resp.addr_ok;

    always_comb begin
        bus_req      = '0;
        bus_req.req  = issue_ok;
        bus_req.size = 2'b10;
        bus_req.addr = {next_pc[31:2], 2'b00};
    end

    // pc_q names the outstanding fetch until the next acceptance
    assign adef = pc_q[1:0] != 2'b00;

    always_comb begin
        ret_item.pc            = pc_q;
        ret_item.inst          = adef ? 32'd0 : bus_resp.rdata;
        ret_item.has_exception = adef;
        ret_item.ecode         = adef ? ECODE_ADEF : 6'd0;
        ret_item.esubcode      = 9'd0;
    end

    assign ret_ok = bus_resp.data_ok && pend_q && !pend_cancel_q && !redirect_now;

    // stale item is hidden in the redirect cycle itself
    assign out_valid = out_valid_q && !redirect_now;
    assign fetch_out = out_q;
    assign out_fire  = out_valid && out_ready;
    assign out_free  = !out_valid_q || out_fire;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_en_q    <= 1'b0;
            pc_q          <= RESET_PC - 32'd4;
            held_kind_q   <= RD_NONE;
            pend_q        <= 1'b0;
            pend_cancel_q <= 1'b0;
        end else begin
            fetch_en_q <= 1'b1;
            if (accept) begin
                pc_q        <= next_pc;
                held_kind_q <= RD_NONE;
            end else begin
                held_kind_q <= eff_kind;
            end
            // a redirect while waiting marks the return as dead
            if (bus_resp.data_ok) begin
                pend_q        <= 1'b0;
                pend_cancel_q <= 1'b0;
            end else if (accept) begin
                pend_q <= 1'b1;
            end else if (redirect_now && pend_q) begin
                pend_cancel_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!accept) begin
            held_target_q <= eff_target;
        end
    end

    // output register with a one-entry skid buffer behind it
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 1'b0;
            buf_valid_q <= 1'b0;
        end else if (redirect_now) begin
            out_valid_q <= 1'b0;
            buf_valid_q <= 1'b0;
        end else if (out_free) begin
            out_valid_q <= buf_valid_q || ret_ok;
            buf_valid_q <= buf_valid_q && ret_ok;
        end else if (ret_ok) begin
            buf_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_q <= buf_valid_q ? buf_q : ret_item;
        end
        if (ret_ok && (buf_valid_q || !out_free)) begin
            buf_q <= ret_item;
        end
    end

endmodule

/* design/lsu_port.sv */
`timescale 1ns/10ps

module lsu_port (
    input  logic               clk,
    input  logic               rst,
    input  logic               lsu_cmd_valid,
    input  cpu_pkg::lsu_op_e   lsu_cmd_op,
    input  logic [31:0]        lsu_addr,
    input  logic [31:0]        lsu_wdata,
    output cpu_pkg::mem_req_t  bus_req,
    input  cpu_pkg::mem_resp_t bus_resp,
    output logic               lsu_done,
    output logic [31:0]        lsu_rdata
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {
        LS_IDLE,
        LS_REQ,
        LS_WAIT
    } lsu_state_e;

    lsu_state_e  state_q;
    lsu_op_e     op_q;
    logic [31:0] addr_q;
    logic [31:0] wdata_q;
    logic        is_store;

    assign is_store = op_q == LSU_STORE;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= LS_IDLE;
            op_q    <= LSU_LOAD;
        end else begin
            case (state_q)
                LS_IDLE: begin
                    if (lsu_cmd_valid) begin
                        state_q <= LS_REQ;
                        op_q    <= lsu_cmd_op;
                    end
                end
                // hold req until the arbiter lets it through
                LS_REQ: begin
                    if (bus_resp.addr_ok) begin
                        state_q <= LS_WAIT;
                    end
                end
                LS_WAIT: begin
                    if (bus_resp.data_ok) begin
                        state_q <= LS_IDLE;
                    end
                end
                default: state_q <= LS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == LS_IDLE && lsu_cmd_valid) begin
            addr_q  <= lsu_addr;
            wdata_q <= lsu_wdata;
        end
    end

    // full-word accesses only
    always_comb begin
        bus_req       = '0;
        bus_req.req   = state_q == LS_REQ;
        bus_req.wr    = is_store;
        bus_req.size  = 2'b10;
        bus_req.addr  = addr_q;
        bus_req.wstrb = is_store ? 4'hf : 4'h0;
        bus_req.wdata = wdata_q;
    end

    assign lsu_done  = state_q == LS_WAIT && bus_resp.data_ok;
    assign lsu_rdata = (lsu_done && !is_store) ? bus_resp.rdata : 32'd0;

endmodule

/* design/bus_arbiter.sv */
`timescale 1ns/10ps

module bus_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::mem_req_t  data_req,
    output cpu_pkg::mem_resp_t data_resp,
    input  cpu_pkg::mem_req_t  fetch_req,
    output cpu_pkg::mem_resp_t fetch_resp,
    output cpu_pkg::mem_req_t  mem_req,
    input  cpu_pkg::mem_resp_t mem_resp
);
    import cpu_pkg::*;

    arb_owner_e owner_q;
    logic       grant_data;
    logic       grant_fetch;
    logic       accept;

    // data master wins a same-cycle contest
    assign grant_data  = data_req.req;
    assign grant_fetch = fetch_req.req && !data_req.req;

    assign mem_req = grant_data ? data_req : fetch_req;
    assign accept  = mem_req.req && mem_resp.addr_ok;

    // who the next data_ok belongs to
    always_ff @(posedge clk) begin
        if (rst) begin
            owner_q <= OWN_NONE;
        end else if (accept) begin
            owner_q <= grant_data ? OWN_DATA : OWN_FETCH;
        end else if (mem_resp.data_ok) begin
            owner_q <= OWN_NONE;
        end
    end

    always_comb begin
        data_resp.addr_ok = mem_resp.addr_ok && grant_data;
        data_resp.data_ok = mem_resp.data_ok && owner_q == OWN_DATA;
        data_resp.rdata   = (owner_q == OWN_DATA) ? mem_resp.rdata : 32'd0;
    end

    always_comb begin
        fetch_resp.addr_ok = mem_resp.addr_ok && grant_fetch;
        fetch_resp.data_ok = mem_resp.data_ok && owner_q == OWN_FETCH;
        fetch_resp.rdata   = (owner_q == OWN_FETCH) ? mem_resp.rdata : 32'd0;
    end

endmodule

/* design/sram_slave.sv */
`timescale 1ns/10ps

module sram_slave (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::mem_req_t  bus_req,
    output cpu_pkg::mem_resp_t bus_resp
);
    import cpu_pkg::*;

    logic [31:0] mem [MEM_WORDS];

    logic [$clog2(MEM_WORDS)-1:0] idx;
    logic                         pend_q;
    logic                         accept;
    logic [31:0]                  rdata_q;

    // word index, upper address bits ignored
    assign idx    = bus_req.addr[$clog2(MEM_WORDS)+1:2];
    assign accept = bus_req.req && !pend_q;

    // one transaction outstanding, answered next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && bus_req.wr) begin
            for (int b = 0; b < 4; b++) begin
                if (bus_req.wstrb[b]) begin
                    mem[idx][8*b +: 8] <= bus_req.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= bus_req.wr ? 32'd0 : mem[idx];
        end
    end

    always_comb begin
        bus_resp.addr_ok = !pend_q;
        bus_resp.data_ok = pend_q;
        bus_resp.rdata   = rdata_q;
    end

endmodule

/* design/fetch_top.sv */
`timescale 1ns/10ps

module fetch_top (
    input  logic                clk,
    input  logic                rst,
    input  cpu_pkg::redirect_e  redirect_kind,
    input  logic [31:0]         redirect_target,
    output cpu_pkg::fetch_out_t fetch_out,
    output logic                out_valid,
    input  logic                out_ready,
    input  logic                lsu_cmd_valid,
    input  cpu_pkg::lsu_op_e    lsu_cmd_op,
    input  logic [31:0]         lsu_addr,
    input  logic [31:0]         lsu_wdata,
    output logic                lsu_done,
    output logic [31:0]         lsu_rdata
);
    import cpu_pkg::*;

    mem_req_t  fetch_req;
    mem_resp_t fetch_resp;
    mem_req_t  data_req;
    mem_resp_t data_resp;
    mem_req_t  mem_req;
    mem_resp_t mem_resp;

    fetch_stage u_fetch_stage (
        .clk             (clk),
        .rst             (rst),
        .redirect_kind   (redirect_kind),
        .redirect_target (redirect_target),
        .bus_req         (fetch_req),
        .bus_resp        (fetch_resp),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .fetch_out       (fetch_out)
    );

    lsu_port u_lsu_port (
        .clk           (clk),
        .rst           (rst),
        .lsu_cmd_valid (lsu_cmd_valid),
        .lsu_cmd_op    (lsu_cmd_op),
        .lsu_addr      (lsu_addr),
        .lsu_wdata     (lsu_wdata),
        .bus_req       (data_req),
        .bus_resp      (data_resp),
        .lsu_done      (lsu_done),
        .lsu_rdata     (lsu_rdata)
    );

    bus_arbiter u_bus_arbiter (
        .clk        (clk),
        .rst        (rst),
        .data_req   (data_req),
        .data_resp  (data_resp),
        .fetch_req  (fetch_req),
        .fetch_resp (fetch_resp),
        .mem_req    (mem_req),
        .mem_resp   (mem_resp)
    );

    sram_slave u_sram_slave (
        .clk      (clk),
        .rst      (rst),
        .bus_req  (mem_req),
        .bus_resp (mem_resp)
    );

endmodule

/* tb/fetch_top_chk.sv */
`timescale 1ns/10ps

module fetch_top_chk (
    input logic                clk,
    input logic                rst,
    input logic                out_valid,
    input logic                out_ready,
    input cpu_pkg::fetch_out_t fetch_out,
    input cpu_pkg::mem_req_t   data_req,
    input cpu_pkg::mem_resp_t  data_resp,
    input cpu_pkg::mem_resp_t  fetch_resp,
    input cpu_pkg::mem_req_t   mem_req,
    input cpu_pkg::mem_resp_t  mem_resp
);
    import cpu_pkg::*;

    // stalled item stays put until decode takes it
    a_hold_stalled: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(fetch_out))
        else $error("fetch output changed while stalled");

    // return goes to the one master whose request was taken
    a_single_return: assert property (@(posedge clk) disable iff (rst)
        mem_resp.data_ok |-> (data_resp.data_ok != fetch_resp.data_ok)
            && (data_resp.data_ok == $past(data_req.req && data_resp.addr_ok)))
        else $error("data_ok not routed to the accepted master alone");

    // every return answers a request accepted the cycle before
    a_return_follows_accept: assert property (@(posedge clk) disable iff (rst)
        mem_resp.data_ok |-> $past(mem_req.req && mem_resp.addr_ok))
        else $error("data_ok without an accepted request");

endmodule

bind fetch_top fetch_top_chk u_fetch_top_chk (
    .clk        (clk),
    .rst        (rst),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .fetch_out  (fetch_out),
    .data_req   (data_req),
    .data_resp  (data_resp),
    .fetch_resp (fetch_resp),
    .mem_req    (mem_req),
    .mem_resp   (mem_resp)
);

/* tb/fetch_top_tb.sv */
`timescale 1ns/10ps

module fetch_top_tb;
    import cpu_pkg::*;

    localparam int HALF_PERIOD = 20;

    logic        clk;
    logic        rst;
    redirect_e   redirect_kind;
    logic [31:0] redirect_target;
    fetch_out_t  fetch_out;
    logic        out_valid;
    logic        out_ready;
    logic        lsu_cmd_valid;
    lsu_op_e     lsu_cmd_op;
    logic [31:0] lsu_addr;
    logic [31:0] lsu_wdata;
    logic        lsu_done;
    logic [31:0] lsu_rdata;

    // vectors as read from the data file
    byte         vec_op [$];
    logic [31:0] vec_a [$];
    logic [31:0] vec_b [$];

    logic [31:0] image [MEM_WORDS];
    logic        written [MEM_WORDS];
    logic [31:0] lcg_state = 32'heacba917;
    logic        fetch_mode = 1'b0;
    logic [31:0] exp_pc = RESET_PC;
    int          accepted_count = 0;
    logic        last_accept = 1'b0;
    logic        done_seen = 1'b0;
    logic [31:0] rdata_seen = 32'd0;
    int          cycles = 0;
    int          cycle_limit = 1000;

    fetch_top u_fetch_top (
        .clk             (clk),
        .rst             (rst),
        .redirect_kind   (redirect_kind),
        .redirect_target (redirect_target),
        .fetch_out       (fetch_out),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .lsu_cmd_valid   (lsu_cmd_valid),
        .lsu_cmd_op      (lsu_cmd_op),
        .lsu_addr        (lsu_addr),
        .lsu_wdata       (lsu_wdata),
        .lsu_done        (lsu_done),
        .lsu_rdata       (lsu_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // hung run guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $fatal(1);
        end
    end

    function automatic logic next_ready();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        // roughly one cycle in four stalls decode
        return lcg_state[31:30] != 2'b00;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_item();
        logic [7:0] idx;
        idx = exp_pc[9:2];
        check_value("fetch_out.pc", exp_pc, fetch_out.pc);
        if (exp_pc[1:0] != 2'b00) begin
            check_value("fetch_out.has_exception", 32'd1, {31'd0, fetch_out.has_exception});
            check_value("fetch_out.ecode", {26'd0, ECODE_ADEF}, {26'd0, fetch_out.ecode});
            check_value("fetch_out.esubcode", 32'd0, {23'd0, fetch_out.esubcode});
            check_value("fetch_out.inst", 32'd0, fetch_out.inst);
        end else begin
            if (!written[idx]) begin
                $display("fetch reached pc %h, which no store line has filled", exp_pc);
                $display("Test failed");
                $fatal(1);
            end
            check_value("fetch_out.has_exception", 32'd0, {31'd0, fetch_out.has_exception});
            check_value("fetch_out.inst", image[idx], fetch_out.inst);
        end
        exp_pc = exp_pc + 32'd4;
        accepted_count++;
    endtask

    // inputs change on the falling edge, outputs are read just before the rising one
    task automatic step(input logic cmd_v, input lsu_op_e op, input logic [31:0] addr,
                        input logic [31:0] data, input redirect_e rk, input logic [31:0] rt);
        @(negedge clk);
        lsu_cmd_valid   = cmd_v;
        lsu_cmd_op      = op;
        lsu_addr        = addr;
        lsu_wdata       = data;
        redirect_kind   = rk;
        redirect_target = rt;
        out_ready       = fetch_mode ? next_ready() : 1'b1;
        #(HALF_PERIOD - 1);
        last_accept = 1'b0;
        if (lsu_done) begin
            done_seen  = 1'b1;
            rdata_seen = lsu_rdata;
        end
        if (fetch_mode && out_valid && out_ready) begin
            last_accept = 1'b1;
            check_item();
        end
    endtask

    task automatic idle_cycle();
        step(1'b0, LSU_LOAD, 32'd0, 32'd0, RD_NONE, 32'd0);
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst           = 1'b1;
        out_ready     = 1'b0;
        lsu_cmd_valid = 1'b0;
        redirect_kind = RD_NONE;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic lsu_access(input lsu_op_e op, input logic [31:0] addr,
                              input logic [31:0] data);
        done_seen = 1'b0;
        step(1'b1, op, addr, data, RD_NONE, 32'd0);
        while (!done_seen) begin
            idle_cycle();
        end
    endtask

    // memory is loaded, so restart the core and follow it from RESET_PC
    task automatic enter_fetch();
        fetch_mode = 1'b0;
        reset_dut();
        exp_pc         = RESET_PC;
        accepted_count = 0;
        last_accept    = 1'b0;
        fetch_mode     = 1'b1;
    endtask

    task automatic read_vectors();
        int          fd;
        int          n;
        int          total;
        string       line;
        byte         op;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("tb/fetch_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file tb/fetch_vectors.txt");
            $display("Test failed");
            $fatal(1);
        end
        total = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                a = 32'd0;
                b = 32'd0;
                n = $sscanf(line, "%c %h %h", op, a, b);
                vec_op.push_back(op);
                vec_a.push_back(a);
                vec_b.push_back(b);
                total = total + 1 + ((op == "R") ? int'(a) : 0);
            end
        end
        $fclose(fd);
        cycle_limit = 50 * total;
    endtask

    initial begin
        int target;
        rst             = 1'b1;
        redirect_kind   = RD_NONE;
        redirect_target = 32'd0;
        out_ready       = 1'b0;
        lsu_cmd_valid   = 1'b0;
        lsu_cmd_op      = LSU_LOAD;
        lsu_addr        = 32'd0;
        lsu_wdata       = 32'd0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            written[i] = 1'b0;
            image[i]   = 32'd0;
        end
        read_vectors();
        reset_dut();
        for (int i = 0; i < vec_op.size(); i++) begin
            case (vec_op[i])
                "S": begin
                    lsu_access(LSU_STORE, vec_a[i], vec_b[i]);
                    image[vec_a[i][9:2]]   = vec_b[i];
                    written[vec_a[i][9:2]] = 1'b1;
                end
                "L": begin
                    lsu_access(LSU_LOAD, vec_a[i], 32'd0);
                    check_value("lsu_rdata", vec_b[i], rdata_seen);
                end
                "R": begin
                    if (!fetch_mode) enter_fetch();
                    target = accepted_count + int'(vec_a[i]);
                    while (accepted_count < target) begin
                        idle_cycle();
                    end
                end
                "D": begin
                    if (!fetch_mode) enter_fetch();
                    while (!last_accept) begin
                        idle_cycle();
                    end
                    exp_pc = vec_b[i];
                    step(1'b0, LSU_LOAD, 32'd0, 32'd0, redirect_e'(vec_a[i][1:0]), vec_b[i]);
                end
                default: begin
                    $display("vector line %0d has an unknown command", i);
                    $display("Test failed");
                    $fatal(1);
                end
            endcase
        end
        $display("Test passed");
        $finish;
    end

endmodule

/* tb/fetch_vectors.txt */
# S addr data : store a word / L addr data : load a word, expect data
# R count : accept count fetched items / D kind target : redirect (1 branch, 2 exc, 3 ertn)
S 1c000000 02800c21
S 1c000004 02801042
S 1c000008 00101063
S 1c00000c 0015008a
S 1c000010 58001064
S 1c000020 02bffc21
S 1c000024 28c00085
S 1c000028 29c000a6
S 1c00002c 4c000020
S 1c000030 06483800
L 1c000000 02800c21
L 1c000024 28c00085
L 1c000010 58001064
R 4
D 1 1c000020
R 3
D 2 1c000008
R 2
D 3 1c000028
R 2
D 1 1c000002
R 2
D 1 1c000004
R 2

/* files.f */
design/cpu_pkg.sv
design/fetch_stage.sv
design/lsu_port.sv
design/bus_arbiter.sv
design/sram_slave.sv
design/fetch_top.sv
tb/fetch_top_chk.sv
tb/fetch_top_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = fetch_top_tb
FILELIST = files.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
